// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_ex_stage
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= sim passed
VFLAGS    ?= --binary --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run $(TOP)"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== alu/alu_arith.sv ====
`default_nettype none

module alu_arith (
    input  wire ex_pkg::aluop_t aluop_i,
    input  wire ex_pkg::word_t  reg1_i,
    input  wire ex_pkg::word_t  reg2_i,
    output ex_pkg::word_t       arith_o,
    output logic                ov_o
);

    localparam int msb = ex_pkg::data_w - 1;

    ex_pkg::word_t reg2_mux;
    ex_pkg::word_t sum;
    logic          lt;

    // number of zero bits above the first one, 32 for an all-zero word
    function automatic ex_pkg::word_t lead_zeros(input ex_pkg::word_t v);
        ex_pkg::word_t n;
        logic          seen_one;
        n        = '0;
        seen_one = 1'b0;
        for (int i = msb; i >= 0; i--) begin
            seen_one = seen_one | v[i];
            if (!seen_one) begin
                n = n + 1'b1;
            end
        end
        return n;
    endfunction

    // subtract by adding the two's complement
    assign reg2_mux = (aluop_i == ex_pkg::op_sub || aluop_i == ex_pkg::op_subu ||
                       aluop_i == ex_pkg::op_slt) ? (~reg2_i) + 1'b1 : reg2_i;
    assign sum      = reg1_i + reg2_mux;

    // same signs in, other sign out
    assign ov_o = (!reg1_i[msb] && !reg2_mux[msb] && sum[msb]) ||
                  (reg1_i[msb] && reg2_mux[msb] && !sum[msb]);

    // signed: neg < pos, else sign of the difference
    assign lt = (aluop_i == ex_pkg::op_slt) ?
                ((reg1_i[msb] && !reg2_i[msb]) ||
                 (reg1_i[msb] == reg2_i[msb] && sum[msb])) :
                (reg1_i < reg2_i);

    always_comb begin
        case (aluop_i)
            ex_pkg::op_slt, ex_pkg::op_sltu:   arith_o = ex_pkg::word_t'(lt);
            ex_pkg::op_add, ex_pkg::op_addu,
            ex_pkg::op_addi, ex_pkg::op_addiu: arith_o = sum;
            ex_pkg::op_sub, ex_pkg::op_subu:   arith_o = sum;
            ex_pkg::op_clz:                    arith_o = lead_zeros(reg1_i);
            ex_pkg::op_clo:                    arith_o = lead_zeros(~reg1_i);  // ones as zeros
            default:                           arith_o = '0;
        endcase
    end

    always_comb begin
        if (aluop_i == ex_pkg::op_clz || aluop_i == ex_pkg::op_clo) begin
            a_count_range: assert (arith_o <= ex_pkg::word_t'(ex_pkg::data_w))
                else $error("leading bit count %0d exceeds word width", arith_o);
        end
    end

endmodule

`default_nettype wire

// ==== alu/alu_logic_shift.sv ====
`default_nettype none

module alu_logic_shift (
    input  wire ex_pkg::aluop_t aluop_i,
    input  wire ex_pkg::word_t  reg1_i,
    input  wire ex_pkg::word_t  reg2_i,
    output ex_pkg::word_t       logic_o,
    output ex_pkg::word_t       shift_o
);

    logic [ex_pkg::shamt_w-1:0] shamt;

    assign shamt = reg1_i[ex_pkg::shamt_w-1:0];  // only the low 5 bits count

    // bitwise group
    always_comb begin
        case (aluop_i)
            ex_pkg::op_or: begin
                logic_o = reg1_i | reg2_i;
            end
            ex_pkg::op_and: begin
                logic_o = reg1_i & reg2_i;
            end
            ex_pkg::op_nor: begin
                logic_o = ~(reg1_i | reg2_i);
            end
            ex_pkg::op_xor: begin
                logic_o = reg1_i ^ reg2_i;
            end
            default: logic_o = '0;
        endcase
    end

    // reg2 is the value, reg1 the amount
    always_comb begin
        case (aluop_i)
            ex_pkg::op_sll: begin
                shift_o = reg2_i << shamt;
            end
            ex_pkg::op_srl: begin
                shift_o = reg2_i >> shamt;
            end
            ex_pkg::op_sra: begin
                shift_o = $signed(reg2_i) >>> shamt;  // sign bit fills from the left
            end
            default: shift_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== common/ex_pkg.sv ====
`default_nettype none

package ex_pkg;

    // data path widths
    localparam int data_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int aluop_w    = 8;
    localparam int alusel_w   = 3;
    localparam int shamt_w    = 5;  // low bits of reg1 used as shift amount

    typedef logic [data_w-1:0]     word_t;
    typedef logic [2*data_w-1:0]   dword_t;   // product or {hi, lo}
    typedef logic [reg_addr_w-1:0] reg_addr_t;
    typedef logic [aluop_w-1:0]    aluop_t;
    typedef logic [alusel_w-1:0]   alusel_t;

    // logic ops
    localparam aluop_t op_and   = 8'b0010_0100;
    localparam aluop_t op_or    = 8'b0010_0101;
    localparam aluop_t op_xor   = 8'b0010_0110;
    localparam aluop_t op_nor   = 8'b0010_0111;

    // shifts
    localparam aluop_t op_sll   = 8'b0111_1100;
    localparam aluop_t op_srl   = 8'b0000_0010;
    localparam aluop_t op_sra   = 8'b0000_0011;

    // moves, conditional moves pass reg1 through
    localparam aluop_t op_movz  = 8'b0000_1010;
    localparam aluop_t op_movn  = 8'b0000_1011;
    localparam aluop_t op_mfhi  = 8'b0001_0000;
    localparam aluop_t op_mthi  = 8'b0001_0001;
    localparam aluop_t op_mflo  = 8'b0001_0010;
    localparam aluop_t op_mtlo  = 8'b0001_0011;

    // simple arithmetic
    localparam aluop_t op_slt   = 8'b0010_1010;
    localparam aluop_t op_sltu  = 8'b0010_1011;
    localparam aluop_t op_add   = 8'b0010_0000;
    localparam aluop_t op_addu  = 8'b0010_0001;
    localparam aluop_t op_sub   = 8'b0010_0010;
    localparam aluop_t op_subu  = 8'b0010_0011;
    localparam aluop_t op_addi  = 8'b0101_0101;
    localparam aluop_t op_addiu = 8'b0101_0110;
    localparam aluop_t op_clz   = 8'b1011_0000;
    localparam aluop_t op_clo   = 8'b1011_0001;

    // multiply
    localparam aluop_t op_mult  = 8'b0001_1000;
    localparam aluop_t op_multu = 8'b0001_1001;
    localparam aluop_t op_mul   = 8'b1010_1001;  // low word to rd, hi/lo untouched

    // result groups, picked by alusel
    localparam alusel_t sel_nop   = 3'b000;
    localparam alusel_t sel_logic = 3'b001;
    localparam alusel_t sel_shift = 3'b010;
    localparam alusel_t sel_move  = 3'b011;
    localparam alusel_t sel_arith = 3'b100;
    localparam alusel_t sel_mul   = 3'b101;

endpackage

`default_nettype wire

// ==== mul/mul_unit.sv ====
`default_nettype none

module mul_unit (
    input  wire ex_pkg::aluop_t aluop_i,
    input  wire ex_pkg::word_t  reg1_i,
    input  wire ex_pkg::word_t  reg2_i,
    output ex_pkg::dword_t      prod_o
);

    localparam int msb = ex_pkg::data_w - 1;

    logic           is_signed;
    ex_pkg::word_t  opa;        // magnitude of reg1 for signed ops
    ex_pkg::word_t  opb;
    ex_pkg::dword_t mag_prod;

    // mul and mult are signed, multu takes raw operands
    assign is_signed = (aluop_i == ex_pkg::op_mul) || (aluop_i == ex_pkg::op_mult);

    assign opa = (is_signed && reg1_i[msb]) ? (~reg1_i) + 1'b1 : reg1_i;
    assign opb = (is_signed && reg2_i[msb]) ? (~reg2_i) + 1'b1 : reg2_i;

    // unsigned 32x32, zero extended to 64
    assign mag_prod = ex_pkg::dword_t'(opa) * ex_pkg::dword_t'(opb);

    always_comb begin
        if (is_signed && (reg1_i[msb] ^ reg2_i[msb])) begin
            prod_o = (~mag_prod) + 1'b1;  // signs differ
        end else begin
            prod_o = mag_prod;
        end
    end

endmodule

`default_nettype wire

// ==== project.f ====
common/ex_pkg.sv
alu/alu_logic_shift.sv
alu/alu_arith.sv
mul/mul_unit.sv
verilog/hilo_file.sv
verilog/ex_mem_reg.sv
verilog/ex_stage.sv
tests/tb_ex_stage.sv

// ==== tests/tb_ex_stage.sv ====
`default_nettype none

module tb_ex_stage;

    localparam int drain_limit = 20;  // cycles allowed for out_valid_o to drop

    logic                 clk;
    logic                 reset_i;
    logic                 in_valid_i;
    ex_pkg::aluop_t       aluop_i;
    ex_pkg::alusel_t      alusel_i;
    ex_pkg::word_t        reg1_i;
    ex_pkg::word_t        reg2_i;
    ex_pkg::reg_addr_t    wd_i;
    logic                 wreg_i;
    wire                  out_valid_o;
    wire ex_pkg::reg_addr_t wd_o;
    wire                  wreg_o;
    wire ex_pkg::word_t   wdata_o;

    // expected result of the instruction driven this cycle, and one cycle later
    logic              exp_valid_d = 1'b0;
    logic              exp_wreg_d  = 1'b0;
    ex_pkg::word_t     exp_wdata_d = '0;
    ex_pkg::reg_addr_t exp_wd_d    = '0;
    logic              exp_valid_q = 1'b0;
    logic              exp_wreg_q  = 1'b0;
    ex_pkg::word_t     exp_wdata_q = '0;
    ex_pkg::reg_addr_t exp_wd_q    = '0;
    logic              armed       = 1'b0;  // first edge seen
    logic              rst_q       = 1'b0;

    ex_pkg::word_t m_hi = '0;  // hi/lo model
    ex_pkg::word_t m_lo = '0;
    int            errors   = 0;
    int            timeouts = 0;
    int            issued   = 0;

    ex_pkg::aluop_t ls_ops [7] = '{ex_pkg::op_or, ex_pkg::op_and, ex_pkg::op_nor,
                                   ex_pkg::op_xor, ex_pkg::op_sll, ex_pkg::op_srl,
                                   ex_pkg::op_sra};
    ex_pkg::aluop_t ar_ops [8] = '{ex_pkg::op_add, ex_pkg::op_addu, ex_pkg::op_addi,
                                   ex_pkg::op_addiu, ex_pkg::op_sub, ex_pkg::op_subu,
                                   ex_pkg::op_slt, ex_pkg::op_sltu};

    ex_stage u_ex_stage (
        .clk         (clk),
        .reset_i     (reset_i),
        .in_valid_i  (in_valid_i),
        .aluop_i     (aluop_i),
        .alusel_i    (alusel_i),
        .reg1_i      (reg1_i),
        .reg2_i      (reg2_i),
        .wd_i        (wd_i),
        .wreg_i      (wreg_i),
        .out_valid_o (out_valid_o),
        .wd_o        (wd_o),
        .wreg_o      (wreg_o),
        .wdata_o     (wdata_o)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        armed <= 1'b1;
        rst_q <= reset_i;
        if (reset_i) begin
            exp_valid_q <= 1'b0;
            exp_wreg_q  <= 1'b0;
        end else begin
            exp_valid_q <= exp_valid_d;
            exp_wreg_q  <= exp_wreg_d;
            exp_wdata_q <= exp_wdata_d;
            exp_wd_q    <= exp_wd_d;
        end
    end

    a_valid: assert property (@(posedge clk) armed |-> out_valid_o == exp_valid_q)
        else begin
            errors++;
            $display("ERR %0t: out_valid_o is %0b, expected %0b", $time,
                     $sampled(out_valid_o), $sampled(exp_valid_q));
        end

    a_wreg: assert property (@(posedge clk) armed |-> wreg_o == exp_wreg_q)
        else begin
            errors++;
            $display("ERR %0t: wreg_o is %0b, expected %0b", $time,
                     $sampled(wreg_o), $sampled(exp_wreg_q));
        end

    a_data: assert property (@(posedge clk) armed && exp_valid_q |->
                             wdata_o == exp_wdata_q && wd_o == exp_wd_q)
        else begin
            errors++;
            $display("ERR %0t: wdata_o %h wd_o %0d, expected %h and %0d", $time,
                     $sampled(wdata_o), $sampled(wd_o), $sampled(exp_wdata_q),
                     $sampled(exp_wd_q));
        end

    a_reset: assert property (@(posedge clk) armed && rst_q |->
                              !out_valid_o && !wreg_o && wdata_o == '0 && wd_o == '0)
        else begin
            errors++;
            $display("ERR %0t: outputs not cleared by reset", $time);
        end

    // result group for each operation, as decode would give it
    function automatic ex_pkg::alusel_t sel_for_op(input ex_pkg::aluop_t op);
        case (op)
            ex_pkg::op_or, ex_pkg::op_and, ex_pkg::op_nor, ex_pkg::op_xor: return ex_pkg::sel_logic;
            ex_pkg::op_sll, ex_pkg::op_srl, ex_pkg::op_sra:                return ex_pkg::sel_shift;
            ex_pkg::op_mfhi, ex_pkg::op_mflo,
            ex_pkg::op_movz, ex_pkg::op_movn:                              return ex_pkg::sel_move;
            ex_pkg::op_mul:                                                return ex_pkg::sel_mul;
            ex_pkg::op_mult, ex_pkg::op_multu,
            ex_pkg::op_mthi, ex_pkg::op_mtlo:                              return ex_pkg::sel_nop;
            default:                                                       return ex_pkg::sel_arith;
        endcase
    endfunction

    // highest bit that differs from bitval decides the count
    function automatic ex_pkg::word_t count_lead(input ex_pkg::word_t v, input logic bitval);
        int n;
        n = 32;
        for (int i = 0; i < 32; i++) begin
            if (v[i] != bitval) begin
                n = 31 - i;
            end
        end
        return ex_pkg::word_t'(n);
    endfunction

    function automatic ex_pkg::dword_t prod_signed(input ex_pkg::word_t a, input ex_pkg::word_t b);
        return $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
    endfunction

    function automatic ex_pkg::dword_t prod_unsigned(input ex_pkg::word_t a, input ex_pkg::word_t b);
        return {32'h0, a} * {32'h0, b};
    endfunction

    function automatic void ref_result(input ex_pkg::aluop_t op, input ex_pkg::word_t r1,
                                       input ex_pkg::word_t r2, input logic wr_in,
                                       output ex_pkg::word_t res, output logic wr);
        logic [32:0]                ext;  // sign extended sum or difference
        logic [ex_pkg::shamt_w-1:0] s;
        ex_pkg::dword_t             p;
        logic                       ovf;
        s   = r1[ex_pkg::shamt_w-1:0];
        ext = '0;
        ovf = 1'b0;
        p   = prod_signed(r1, r2);
        case (op)
            ex_pkg::op_or:   res = r1 | r2;
            ex_pkg::op_and:  res = r1 & r2;
            ex_pkg::op_nor:  res = ~(r1 | r2);
            ex_pkg::op_xor:  res = r1 ^ r2;
            ex_pkg::op_sll:  res = r2 << s;
            ex_pkg::op_srl:  res = r2 >> s;
            ex_pkg::op_sra:  res = (r2 >> s) | (r2[31] ? ~(32'hffff_ffff >> s) : 32'h0);
            ex_pkg::op_add, ex_pkg::op_addu, ex_pkg::op_addi, ex_pkg::op_addiu: begin
                ext = {r1[31], r1} + {r2[31], r2};
                res = ext[31:0];
                ovf = ext[32] ^ ext[31];
            end
            ex_pkg::op_sub, ex_pkg::op_subu: begin
                ext = {r1[31], r1} - {r2[31], r2};
                res = ext[31:0];
                ovf = ext[32] ^ ext[31];
            end
            ex_pkg::op_slt:  res = {31'h0, $signed(r1) < $signed(r2)};
            ex_pkg::op_sltu: res = {31'h0, r1 < r2};
            ex_pkg::op_clz:  res = count_lead(r1, 1'b0);
            ex_pkg::op_clo:  res = count_lead(r1, 1'b1);
            ex_pkg::op_mul:  res = p[31:0];
            ex_pkg::op_mfhi: res = m_hi;
            ex_pkg::op_mflo: res = m_lo;
            ex_pkg::op_movz, ex_pkg::op_movn: res = r1;
            default:         res = '0;  // mult, multu, mthi, mtlo write no gpr
        endcase
        wr = wr_in && !(ovf && (op == ex_pkg::op_add || op == ex_pkg::op_addi ||
                                op == ex_pkg::op_sub));
    endfunction

    task automatic issue(input ex_pkg::aluop_t op, input ex_pkg::word_t r1,
                         input ex_pkg::word_t r2);
        ex_pkg::word_t res;
        logic          wr;
        logic          wr_in;
        @(negedge clk);
        wr_in      = sel_for_op(op) != ex_pkg::sel_nop;
        in_valid_i = 1'b1;
        aluop_i    = op;
        alusel_i   = sel_for_op(op);
        reg1_i     = r1;
        reg2_i     = r2;
        wd_i       = ex_pkg::reg_addr_t'($urandom);
        wreg_i     = wr_in;
        ref_result(op, r1, r2, wr_in, res, wr);
        exp_valid_d = 1'b1;
        exp_wreg_d  = wr;
        exp_wdata_d = res;
        exp_wd_d    = wd_i;
        case (op)  // model sees the write at this same edge
            ex_pkg::op_mult:  {m_hi, m_lo} = prod_signed(r1, r2);
            ex_pkg::op_multu: {m_hi, m_lo} = prod_unsigned(r1, r2);
            ex_pkg::op_mthi:  m_hi = r1;
            ex_pkg::op_mtlo:  m_lo = r1;
            default: ;
        endcase
        issued++;
    endtask

    // no strobe, but junk on the other inputs
    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            in_valid_i  = 1'b0;
            wreg_i      = 1'b1;
            aluop_i     = ex_pkg::op_mthi;
            reg1_i      = $urandom;
            exp_valid_d = 1'b0;
            exp_wreg_d  = 1'b0;
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        idle(1);
        do begin
            @(negedge clk);
            cycles++;
        end while (out_valid_o !== 1'b0 && cycles < drain_limit);
        if (out_valid_o !== 1'b0) begin
            timeouts++;
            $display("timeout: out_valid_o did not drop after the last instruction");
        end
    endtask

    initial begin
        void'($urandom(75));
        clk        = 1'b0;
        reset_i    = 1'b1;
        in_valid_i = 1'b0;
        aluop_i    = '0;
        alusel_i   = '0;
        reg1_i     = '0;
        reg2_i     = '0;
        wd_i       = '0;
        wreg_i     = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        issue(ex_pkg::op_mfhi, 0, 0);  // hi/lo zero after reset
        issue(ex_pkg::op_mflo, 0, 0);
        idle(2);
        for (int i = 0; i < 28; i++) begin
            issue(ls_ops[i % 7], $urandom, $urandom);
        end
        issue(ex_pkg::op_sra, 32'd0, 32'h8000_1234);
        issue(ex_pkg::op_sra, 32'd31, 32'h8765_4321);
        issue(ex_pkg::op_sra, 32'hffff_ffe5, 32'hf000_0000);  // upper amount bits ignored
        issue(ex_pkg::op_sll, 32'd31, $urandom);
        issue(ex_pkg::op_srl, 32'd31, 32'h8000_0000);
        idle(1);
        for (int i = 0; i < 32; i++) begin
            issue(ar_ops[i % 8], $urandom, $urandom);
        end
        issue(ex_pkg::op_add, 32'h7fff_ffff, 32'd1);  // overflow, write dropped
        issue(ex_pkg::op_addi, 32'h8000_0000, 32'h8000_0000);
        issue(ex_pkg::op_sub, 32'h8000_0000, 32'd1);
        issue(ex_pkg::op_addu, 32'h7fff_ffff, 32'd1);  // no trap forms
        issue(ex_pkg::op_addiu, 32'h8000_0000, 32'h8000_0000);
        issue(ex_pkg::op_subu, 32'h8000_0000, 32'd1);
        issue(ex_pkg::op_slt, 32'hffff_ffff, 32'd1);
        issue(ex_pkg::op_sltu, 32'hffff_ffff, 32'd1);
        idle(1);
        issue(ex_pkg::op_clz, 32'h0, 0);
        issue(ex_pkg::op_clo, 32'hffff_ffff, 0);
        issue(ex_pkg::op_clz, 32'hffff_ffff, 0);
        issue(ex_pkg::op_clo, 32'h0, 0);
        for (int i = 0; i < 10; i++) begin
            issue(ex_pkg::op_clz, ex_pkg::word_t'($urandom) >> ($urandom % 32), 0);
            issue(ex_pkg::op_clo, ~(ex_pkg::word_t'($urandom) >> ($urandom % 32)), 0);
        end
        idle(2);
        for (int i = 0; i < 8; i++) begin
            issue((i % 2 == 0) ? ex_pkg::op_mult : ex_pkg::op_multu, $urandom, $urandom);
            issue(ex_pkg::op_mfhi, 0, 0);
            issue(ex_pkg::op_mflo, 0, 0);
        end
        issue(ex_pkg::op_mul, $urandom, $urandom);  // hi/lo untouched
        issue(ex_pkg::op_mfhi, 0, 0);
        issue(ex_pkg::op_mflo, 0, 0);
        issue(ex_pkg::op_mthi, $urandom, 0);
        issue(ex_pkg::op_mflo, 0, 0);
        issue(ex_pkg::op_mtlo, $urandom, 0);
        issue(ex_pkg::op_mfhi, 0, 0);
        issue(ex_pkg::op_mflo, 0, 0);
        issue(ex_pkg::op_movz, $urandom, 0);
        issue(ex_pkg::op_movn, $urandom, $urandom);
        wait_drain();
        $display("done: %0d instructions, %0d errors, %0d timeouts", issued, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/ex_mem_reg.sv ====
`default_nettype none

module ex_mem_reg (
    input  wire                    clk,
    input  wire                    reset_i,
    input  wire                    in_valid_i,
    input  wire ex_pkg::aluop_t    aluop_i,
    input  wire ex_pkg::alusel_t   alusel_i,
    input  wire ex_pkg::word_t     reg1_i,
    input  wire ex_pkg::reg_addr_t wd_i,
    input  wire                    wreg_i,
    input  wire ex_pkg::word_t     logic_i,
    input  wire ex_pkg::word_t     shift_i,
    input  wire ex_pkg::word_t     arith_i,
    input  wire                    ov_i,
    input  wire ex_pkg::dword_t    prod_i,
    input  wire ex_pkg::word_t     hi_i,
    input  wire ex_pkg::word_t     lo_i,
    output logic                   out_valid_o,
    output ex_pkg::reg_addr_t      wd_o,
    output logic                   wreg_o,
    output ex_pkg::word_t          wdata_o
);

    ex_pkg::word_t move_res;
    ex_pkg::word_t wdata_d;
    logic          ov_cancel;

    always_comb begin
        case (aluop_i)
            ex_pkg::op_mfhi:                 move_res = hi_i;
            ex_pkg::op_mflo:                 move_res = lo_i;
            ex_pkg::op_movz, ex_pkg::op_movn: move_res = reg1_i;  // condition checked in decode
            default:                         move_res = '0;
        endcase
    end

    always_comb begin
        case (alusel_i)
            ex_pkg::sel_logic: wdata_d = logic_i;
            ex_pkg::sel_shift: wdata_d = shift_i;
            ex_pkg::sel_move:  wdata_d = move_res;
            ex_pkg::sel_arith: wdata_d = arith_i;
            ex_pkg::sel_mul:   wdata_d = prod_i[ex_pkg::data_w-1:0];  // mul keeps the low word
            ex_pkg::sel_nop:   wdata_d = '0;
            default:           wdata_d = '0;
        endcase
    end

    // only the trapping forms drop the write on overflow
    assign ov_cancel = ov_i && (aluop_i == ex_pkg::op_add || aluop_i == ex_pkg::op_addi ||
                                aluop_i == ex_pkg::op_sub);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            out_valid_o <= 1'b0;
            wreg_o      <= 1'b0;
            wd_o        <= '0;
            wdata_o     <= '0;
        end else begin
            out_valid_o <= in_valid_i;
            wreg_o      <= in_valid_i && wreg_i && !ov_cancel;
            if (in_valid_i) begin
                wd_o    <= wd_i;
                wdata_o <= wdata_d;
            end
        end
    end

    a_wreg_valid: assert property (
        @(posedge clk) disable iff (reset_i)
        wreg_o |-> out_valid_o
    ) else $error("register write flagged without a valid result");

endmodule

`default_nettype wire

// ==== verilog/ex_stage.sv ====
`default_nettype none

module ex_stage (
    input  wire                      clk,
    input  wire                      reset_i,
    input  wire                      in_valid_i,
    input  wire ex_pkg::aluop_t      aluop_i,
    input  wire ex_pkg::alusel_t     alusel_i,
    input  wire ex_pkg::word_t       reg1_i,
    input  wire ex_pkg::word_t       reg2_i,
    input  wire ex_pkg::reg_addr_t   wd_i,
    input  wire                      wreg_i,
    output wire                      out_valid_o,
    output wire ex_pkg::reg_addr_t   wd_o,
    output wire                      wreg_o,
    output wire ex_pkg::word_t       wdata_o
);

    ex_pkg::word_t  logic_res;
    ex_pkg::word_t  shift_res;
    ex_pkg::word_t  arith_res;
    logic           ov;          // signed overflow of the adder
    ex_pkg::dword_t prod;
    ex_pkg::word_t  hi;
    ex_pkg::word_t  lo;

    alu_logic_shift u_alu_logic_shift (
        .aluop_i (aluop_i),
        .reg1_i  (reg1_i),
        .reg2_i  (reg2_i),
        .logic_o (logic_res),
        .shift_o (shift_res)
    );

    alu_arith u_alu_arith (
        .aluop_i (aluop_i),
        .reg1_i  (reg1_i),
        .reg2_i  (reg2_i),
        .arith_o (arith_res),
        .ov_o    (ov)
    );

    mul_unit u_mul_unit (
        .aluop_i (aluop_i),
        .reg1_i  (reg1_i),
        .reg2_i  (reg2_i),
        .prod_o  (prod)
    );

    // hi/lo updated on the same edge that registers the instruction
    hilo_file u_hilo_file (
        .clk        (clk),
        .reset_i    (reset_i),
        .in_valid_i (in_valid_i),
        .aluop_i    (aluop_i),
        .reg1_i     (reg1_i),
        .prod_i     (prod),
        .hi_o       (hi),
        .lo_o       (lo)
    );

    ex_mem_reg u_ex_mem_reg (
        .clk         (clk),
        .reset_i     (reset_i),
        .in_valid_i  (in_valid_i),
        .aluop_i     (aluop_i),
        .alusel_i    (alusel_i),
        .reg1_i      (reg1_i),
        .wd_i        (wd_i),
        .wreg_i      (wreg_i),
        .logic_i     (logic_res),
        .shift_i     (shift_res),
        .arith_i     (arith_res),
        .ov_i        (ov),
        .prod_i      (prod),
        .hi_i        (hi),
        .lo_i        (lo),
        .out_valid_o (out_valid_o),
        .wd_o        (wd_o),
        .wreg_o      (wreg_o),
        .wdata_o     (wdata_o)
    );

endmodule

`default_nettype wire

// ==== verilog/hilo_file.sv ====
`default_nettype none

module hilo_file (
    input  wire                 clk,
    input  wire                 reset_i,
    input  wire                 in_valid_i,
    input  wire ex_pkg::aluop_t aluop_i,
    input  wire ex_pkg::word_t  reg1_i,
    input  wire ex_pkg::dword_t prod_i,
    output ex_pkg::word_t       hi_o,
    output ex_pkg::word_t       lo_o
);

    ex_pkg::word_t hi_q;
    ex_pkg::word_t lo_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (in_valid_i) begin
            case (aluop_i)
                ex_pkg::op_mult, ex_pkg::op_multu: begin
                    hi_q <= prod_i[2*ex_pkg::data_w-1:ex_pkg::data_w];
                    lo_q <= prod_i[ex_pkg::data_w-1:0];
                end
                ex_pkg::op_mthi: begin
                    hi_q <= reg1_i;  // lo kept
                end
                ex_pkg::op_mtlo: begin
                    lo_q <= reg1_i;
                end
                default: begin
                    // mul and the rest leave hi/lo alone
                end
            endcase
        end
    end

    // read path for mfhi/mflo, already holds the last strobed write
    assign hi_o = hi_q;
    assign lo_o = lo_q;

    // nothing moves hi/lo except a strobed instruction
    a_hilo_hold: assert property (
        @(posedge clk) disable iff (reset_i)
        !in_valid_i |=> $stable(hi_q) && $stable(lo_q)
    ) else $error("hi/lo changed in a cycle without a strobe");

endmodule

`default_nettype wire
